// File: Makefile
TOP = sg1000_bus_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -sv -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// File: design/sg1000_bus.sv
`timescale 1ns/1ps

module sg1000_bus import sg1000_pkg::*; (
	input  logic        sys_clk,
	input  logic        reset,
	input  logic [15:0] addr,
	input  logic [7:0]  wdata,
	input  logic        mreq_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	output logic [7:0]  rdata,
	output logic [14:0] cart_addr,
	input  logic [7:0]  cart_data,
	output logic        cart_rd,
	input  logic [7:0]  vdp_data,
	output logic        vdp_rd,
	output logic        vdp_wr,
	output logic        vdp_mode,
	input  logic [7:0]  joy_a,
	input  logic [7:0]  joy_b,
	output logic        psg_we,
	output logic [2:0]  psg_reg,
	output logic [9:0]  psg_value
);

	bus_src_t mem_src;
	bus_src_t io_src;
	logic [7:0] mem_data;
	logic [7:0] io_data;

	sg1000_mem_map i_mem_map (
		.sys_clk   (sys_clk),
		.reset     (reset),
		.addr      (addr),
		.wdata     (wdata),
		.mreq_n    (mreq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.cart_data (cart_data),
		.cart_addr (cart_addr),
		.cart_rd   (cart_rd),
		.mem_src   (mem_src),
		.mem_data  (mem_data)
	);

	sg1000_io_map i_io_map (
		.sys_clk   (sys_clk),
		.reset     (reset),
		.addr      (addr),
		.wdata     (wdata),
		.iorq_n    (iorq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.vdp_data  (vdp_data),
		.joy_a     (joy_a),
		.joy_b     (joy_b),
		.vdp_rd    (vdp_rd),
		.vdp_wr    (vdp_wr),
		.vdp_mode  (vdp_mode),
		.psg_we    (psg_we),
		.psg_reg   (psg_reg),
		.psg_value (psg_value),
		.io_src    (io_src),
		.io_data   (io_data)
	);

	sg1000_read_mux i_read_mux (
		.sys_clk  (sys_clk),
		.reset    (reset),
		.mem_src  (mem_src),
		.mem_data (mem_data),
		.io_src   (io_src),
		.io_data  (io_data),
		.rdata    (rdata)
	);

	// memory and i/o cycles are exclusive on the z80 bus
	a_mreq_iorq_excl: assert property (
		@(posedge sys_clk) disable iff (reset)
		!(!mreq_n && !iorq_n)
	) else $error("mreq_n and iorq_n both active");

endmodule

// File: design/sg1000_config.svh
`ifndef SG1000_CONFIG_SVH
`define SG1000_CONFIG_SVH

// 2 KB work ram mirrored over c000-ffff
`define SG_WRAM_ADDR_BITS 11

// nothing selected on a read
`define SG_OPEN_BUS 8'h00

// i/o windows matched against addr[7:6]
`define SG_PSG_PORT 2'b01
`define SG_VDP_PORT 2'b10
`define SG_JOY_PORT 2'b11

`endif

// File: design/sg1000_io_map.sv
`timescale 1ns/1ps
`include "sg1000_config.svh"

module sg1000_io_map import sg1000_pkg::*; (
	input  logic        sys_clk,
	input  logic        reset,
	input  logic [15:0] addr,
	input  logic [7:0]  wdata,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic [7:0]  vdp_data,
	input  logic [7:0]  joy_a,
	input  logic [7:0]  joy_b,
	output logic        vdp_rd,
	output logic        vdp_wr,
	output logic        vdp_mode,
	output logic        psg_we,
	output logic [2:0]  psg_reg,
	output logic [9:0]  psg_value,
	output bus_src_t    io_src,
	output logic [7:0]  io_data
);

	psg_byte_t psg_byte;
	logic [1:0] window;
	logic vdp_sel;
	logic psg_sel;
	logic joy_sel;
	logic joy_rd;
	logic [2:0] acc_sel;   // {psg write, vdp write, vdp read}
	logic [2:0] acc_q;
	logic [2:0] acc_d;
	logic [2:0] acc_rise;
	logic [2:0] psg_latch_idx;
	logic [9:0] psg_shadow [8];
	logic [2:0] psg_idx_next;
	logic [9:0] psg_val_next;
	logic psg_tone;

	assign window = addr[7:6];   // only the low byte is decoded
	assign vdp_sel = ~iorq_n & (window == `SG_VDP_PORT);
	assign psg_sel = ~iorq_n & (window == `SG_PSG_PORT);
	assign joy_sel = ~iorq_n & (window == `SG_JOY_PORT);
	assign joy_rd = joy_sel & ~rd_n;

	assign acc_sel = {psg_sel & ~wr_n, vdp_sel & ~wr_n, vdp_sel & ~rd_n};
	assign acc_rise = acc_q & ~acc_d;   // first cycle of each access

	assign psg_byte = wdata;

	// psg register update from the current write byte
	always_comb begin
		if (psg_byte.latch.flag) begin
			psg_idx_next = {psg_byte.latch.channel, psg_byte.latch.kind};
		end else begin
			psg_idx_next = psg_latch_idx;   // data byte goes to last latched reg
		end

		psg_tone = ~psg_idx_next[0] & (psg_idx_next[2:1] != 2'b11);

		if (psg_tone) begin
			if (psg_byte.latch.flag) begin
				psg_val_next = {psg_shadow[psg_idx_next][9:4], psg_byte.latch.data};
			end else begin
				psg_val_next = {psg_byte.dat.data, psg_shadow[psg_idx_next][3:0]};
			end
		end else if (psg_byte.latch.flag) begin
			psg_val_next = {6'd0, psg_byte.latch.data};   // volume or noise
		end else begin
			psg_val_next = {6'd0, psg_byte.dat.data[3:0]};
		end
	end

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			acc_q <= '0;
			acc_d <= '0;
			vdp_rd <= 1'b0;
			vdp_wr <= 1'b0;
			psg_we <= 1'b0;
			psg_latch_idx <= 3'd0;
			io_src <= SRC_NONE;
			for (int i = 0; i < 8; i++) begin
				psg_shadow[i] <= 10'd0;
			end
		end else begin
			acc_q <= acc_sel;
			acc_d <= acc_q;
			vdp_rd <= acc_rise[0];
			vdp_wr <= acc_rise[1];
			psg_we <= acc_rise[2];

			if (acc_rise[2]) begin
				psg_shadow[psg_idx_next] <= psg_val_next;
				if (psg_byte.latch.flag) begin
					psg_latch_idx <= psg_idx_next;
				end
			end

			if (acc_sel[0]) begin
				io_src <= SRC_VDP;
			end else if (joy_rd) begin
				io_src <= SRC_JOY;
			end else begin
				io_src <= SRC_NONE;
			end
		end
	end

	// payload held steady until the next access
	always_ff @(posedge sys_clk) begin
		if (acc_rise[0] | acc_rise[1]) begin
			vdp_mode <= addr[0];   // 0 data, 1 control
		end
		if (acc_rise[2]) begin
			psg_reg <= psg_idx_next;
			psg_value <= psg_val_next;
		end
		if (acc_sel[0]) begin
			io_data <= vdp_data;
		end else if (joy_rd) begin
			io_data <= addr[0] ? joy_b : joy_a;   // odd port is pad b
		end
	end

	// write byte still on the bus when the update is decoded
	a_psg_byte_stable: assert property (
		@(posedge sys_clk) disable iff (reset)
		acc_rise[2] |-> $stable(wdata)
	) else $error("psg write byte changed during the write cycle");

endmodule

// File: design/sg1000_mem_map.sv
`timescale 1ns/1ps
`include "sg1000_config.svh"

module sg1000_mem_map import sg1000_pkg::*; (
	input  logic        sys_clk,
	input  logic        reset,
	input  logic [15:0] addr,
	input  logic [7:0]  wdata,
	input  logic        mreq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic [7:0]  cart_data,
	output logic [14:0] cart_addr,
	output logic        cart_rd,
	output bus_src_t    mem_src,
	output logic [7:0]  mem_data
);

	localparam int unsigned WRAM_DEPTH = 1 << `SG_WRAM_ADDR_BITS;

	logic [7:0] wram [WRAM_DEPTH];
	logic [`SG_WRAM_ADDR_BITS-1:0] wram_addr;
	logic wram_sel;
	logic cart_sel;
	logic wram_rd;
	logic wram_wr;

	assign wram_sel = ~mreq_n & (addr[15:14] == 2'b11);   // c000-ffff
	assign cart_sel = ~mreq_n & (addr[15:14] != 2'b11);   // 0000-bfff
	assign wram_rd = wram_sel & ~rd_n;
	assign wram_wr = wram_sel & ~wr_n;
	assign wram_addr = addr[`SG_WRAM_ADDR_BITS-1:0];   // upper bits ignored, so it mirrors

	assign cart_addr = addr[14:0];
	assign cart_rd = cart_sel & ~rd_n;

	// rewritten on every edge of the strobe with the same byte
	always_ff @(posedge sys_clk) begin
		if (wram_wr) begin
			wram[wram_addr] <= wdata;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			mem_src <= SRC_NONE;
		end else if (wram_rd) begin
			mem_src <= SRC_WRAM;
		end else if (cart_rd) begin
			mem_src <= SRC_CART;
		end else begin
			mem_src <= SRC_NONE;
		end
	end

	// ram and cartridge both land here one edge after the strobe
	always_ff @(posedge sys_clk) begin
		if (wram_rd) begin
			mem_data <= wram[wram_addr];
		end else if (cart_rd) begin
			mem_data <= cart_data;   // cart answers within the cycle
		end
	end

	// a z80 never drives both strobes at once
	a_rd_wr_excl: assert property (
		@(posedge sys_clk) disable iff (reset)
		!(!rd_n && !wr_n)
	) else $error("rd_n and wr_n both active");

endmodule

// File: design/sg1000_pkg.sv
package sg1000_pkg;

	// who answers the current cpu read
	typedef enum logic [2:0] {
		SRC_NONE = 3'd0,
		SRC_WRAM = 3'd1,
		SRC_CART = 3'd2,
		SRC_VDP  = 3'd3,
		SRC_JOY  = 3'd4
	} bus_src_t;

	typedef struct packed {
		logic       flag;     // set for a latch byte
		logic [1:0] channel;
		logic       kind;     // 0 tone/noise, 1 volume
		logic [3:0] data;
	} psg_latch_t;

	typedef struct packed {
		logic       flag;     // clear for a data byte
		logic       spare;
		logic [5:0] data;
	} psg_data_t;

	// one psg write byte, two ways of reading it
	typedef union packed {
		psg_latch_t latch;
		psg_data_t  dat;
	} psg_byte_t;

endpackage

// File: design/sg1000_read_mux.sv
`timescale 1ns/1ps
`include "sg1000_config.svh"

module sg1000_read_mux import sg1000_pkg::*; (
	input  logic       sys_clk,
	input  logic       reset,
	input  bus_src_t   mem_src,
	input  logic [7:0] mem_data,
	input  bus_src_t   io_src,
	input  logic [7:0] io_data,
	output logic [7:0] rdata
);

	logic [7:0] rdata_next;

	// work ram, vdp, cartridge, then joystick
	always_comb begin
		if (mem_src == SRC_WRAM) begin
			rdata_next = mem_data;
		end else if (io_src == SRC_VDP) begin
			rdata_next = io_data;
		end else if (mem_src == SRC_CART) begin
			rdata_next = mem_data;
		end else if (io_src == SRC_JOY) begin
			rdata_next = io_data;
		end else begin
			rdata_next = `SG_OPEN_BUS;   // nobody drives the bus
		end
	end

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			rdata <= 8'h00;
		end else begin
			rdata <= rdata_next;
		end
	end

	// memory and i/o maps must never answer together
	a_one_source: assert property (
		@(posedge sys_clk) disable iff (reset)
		!(mem_src != SRC_NONE && io_src != SRC_NONE)
	) else $error("memory and i/o sources active together");

endmodule

// File: filelist.f
+incdir+design
design/sg1000_pkg.sv
design/sg1000_mem_map.sv
design/sg1000_io_map.sv
design/sg1000_read_mux.sv
design/sg1000_bus.sv
tests/sg1000_bus_tb.sv

// File: tests/sg1000_bus_tb.sv
`timescale 1ns/1ps

module sg1000_bus_tb;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int HOLD_CYCLES = 4;   // cpu holds each bus cycle this long
	localparam int N_PAIRS = 24;

	logic        sys_clk;
	logic        reset;
	logic [15:0] addr;
	logic [7:0]  wdata;
	logic        mreq_n;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic [7:0]  rdata;
	logic [14:0] cart_addr;
	logic [7:0]  cart_data;
	logic        cart_rd;
	logic [7:0]  vdp_data;
	logic        vdp_rd;
	logic        vdp_wr;
	logic        vdp_mode;
	logic [7:0]  joy_a;
	logic [7:0]  joy_b;
	logic        psg_we;
	logic [2:0]  psg_reg;
	logic [9:0]  psg_value;

	string       vec_op [$];
	logic [15:0] vec_addr [$];
	logic [7:0]  vec_wdata [$];
	logic [7:0]  vec_cart [$];
	logic [7:0]  vec_vdp [$];
	logic [7:0]  vec_joy_a [$];
	logic [7:0]  vec_joy_b [$];
	logic [7:0]  vec_expect [$];
	string       vec_name [$];

	logic [7:0]  ram_model [2048];   // one byte per mirrored offset
	logic [9:0]  psg_model [8];
	logic [2:0]  psg_latched;
	logic [31:0] rng_state;
	int          n_checks;
	int          n_errors;
	bit          vectors_ready;

	sg1000_bus i_dut (
		.sys_clk   (sys_clk),
		.reset     (reset),
		.addr      (addr),
		.wdata     (wdata),
		.mreq_n    (mreq_n),
		.iorq_n    (iorq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.rdata     (rdata),
		.cart_addr (cart_addr),
		.cart_data (cart_data),
		.cart_rd   (cart_rd),
		.vdp_data  (vdp_data),
		.vdp_rd    (vdp_rd),
		.vdp_wr    (vdp_wr),
		.vdp_mode  (vdp_mode),
		.joy_a     (joy_a),
		.joy_b     (joy_b),
		.psg_we    (psg_we),
		.psg_reg   (psg_reg),
		.psg_value (psg_value)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("Error: %s expected %0h actual %0h at %0t", name, expected, actual, $time);
		end
	endtask

	function automatic logic [31:0] next_random(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// register write as the sn76489 sees it
	task automatic apply_psg_byte(input logic [7:0] b, output logic [2:0] idx,
			output logic [9:0] val);
		logic is_tone;
		idx = b[7] ? b[6:4] : psg_latched;
		is_tone = (idx[0] == 1'b0) && (idx[2:1] != 2'b11);   // channels 0-2, type 0
		if (!is_tone) begin
			val = {6'd0, b[3:0]};
		end else if (b[7]) begin
			val = {psg_model[idx][9:4], b[3:0]};
		end else begin
			val = {b[5:0], psg_model[idx][3:0]};
		end
		psg_model[idx] = val;
		if (b[7]) begin
			psg_latched = idx;
		end
	endtask

	// one cpu bus cycle entered and left on a falling edge
	task automatic run_bus_cycle(input string op, input logic [15:0] a, input logic [7:0] d,
			input logic [7:0] cart, input logic [7:0] vdp, input logic [7:0] pad_a,
			input logic [7:0] pad_b, input logic [7:0] expected, input string name);
		int rd_pulses;
		int wr_pulses;
		int we_pulses;
		bit is_read;
		bit is_mem;
		bit vdp_hit;
		bit psg_hit;
		logic [2:0] exp_reg;
		logic [9:0] exp_val;
		rd_pulses = 0;
		wr_pulses = 0;
		we_pulses = 0;
		is_read = (op == "MR") || (op == "IR");
		is_mem = (op == "MR") || (op == "MW");
		vdp_hit = !is_mem && (a[7:6] == 2'b10);
		psg_hit = (op == "IW") && (a[7:6] == 2'b01);
		addr = a;
		wdata = is_read ? 8'h00 : d;
		cart_data = cart;
		vdp_data = vdp;
		joy_a = pad_a;
		joy_b = pad_b;
		mreq_n = ~is_mem;
		iorq_n = is_mem;
		rd_n = ~is_read;
		wr_n = is_read;
		for (int i = 0; i < HOLD_CYCLES + 1; i++) begin
			@(negedge sys_clk);
			if (vdp_rd) rd_pulses++;
			if (vdp_wr) wr_pulses++;
			if (psg_we) we_pulses++;
			if (i == 0 && op == "MR") begin
				compare_value({name, "_cart_rd"}, 32'(a[15:14] != 2'b11), 32'(cart_rd));
				if (a[15:14] != 2'b11) begin
					compare_value({name, "_cart_addr"}, 32'(a[14:0]), 32'(cart_addr));
				end
			end
			if (i >= 2 && i < HOLD_CYCLES && is_read) begin
				compare_value(name, 32'(expected), 32'(rdata));   // from edge k+2 on
			end
			if (i == HOLD_CYCLES - 1) begin
				mreq_n = 1'b1;   // release for the idle cycle
				iorq_n = 1'b1;
				rd_n = 1'b1;
				wr_n = 1'b1;
				addr = 16'h0000;
				wdata = 8'h00;
			end
		end
		compare_value({name, "_vdp_rd"}, 32'(op == "IR" && vdp_hit), 32'(rd_pulses));
		compare_value({name, "_vdp_wr"}, 32'(op == "IW" && vdp_hit), 32'(wr_pulses));
		compare_value({name, "_psg_we"}, 32'(psg_hit), 32'(we_pulses));
		if (vdp_hit) begin
			compare_value({name, "_vdp_mode"}, 32'(a[0]), 32'(vdp_mode));
		end
		if (psg_hit) begin
			apply_psg_byte(d, exp_reg, exp_val);
			compare_value({name, "_psg_reg"}, 32'(exp_reg), 32'(psg_reg));
			compare_value({name, "_psg_value"}, 32'(exp_val), 32'(psg_value));
		end
		if (op == "MW" && a[15:14] == 2'b11) begin
			ram_model[a[10:0]] = d;
		end
	endtask

	initial begin
		wait (vectors_ready);
		#((vec_op.size() + N_PAIRS + RESET_CYCLES) * 10 * CLK_PERIOD);
		$display("Timeout: the bus cycles did not finish in the expected time");
		$display("Testbench failed");
		$finish;
	end

	initial begin
		int fd;
		int n_fields;
		string line;
		string op;
		string name;
		logic [15:0] a;
		logic [7:0] d;
		logic [7:0] c;
		logic [7:0] v;
		logic [7:0] ja;
		logic [7:0] jb;
		logic [7:0] e;
		logic [15:0] wa;
		logic [15:0] ra;
		logic [7:0] wd;

		reset = 1'b1;
		addr = 16'h0000;
		wdata = 8'h00;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		cart_data = 8'h00;
		vdp_data = 8'h00;
		joy_a = 8'hff;
		joy_b = 8'hff;
		n_checks = 0;
		n_errors = 0;
		rng_state = 32'hfa56;
		psg_latched = 3'd0;
		for (int r = 0; r < 8; r++) begin
			psg_model[r] = 10'd0;
		end

		fd = $fopen("tests/sg1000_bus_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file tests/sg1000_bus_tests.txt");
			n_errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != "#") begin
					n_fields = $sscanf(line, "%s %h %h %h %h %h %h %h %s",
						op, a, d, c, v, ja, jb, e, name);
					if (n_fields == 9) begin
						vec_op.push_back(op);
						vec_addr.push_back(a);
						vec_wdata.push_back(d);
						vec_cart.push_back(c);
						vec_vdp.push_back(v);
						vec_joy_a.push_back(ja);
						vec_joy_b.push_back(jb);
						vec_expect.push_back(e);
						vec_name.push_back(name);
					end else begin
						$display("A vector line could not be parsed: %s", line);
						n_errors++;
					end
				end
			end
			$fclose(fd);
		end
		if (vec_op.size() == 0) begin
			$display("No test vectors were read");
			n_errors++;
		end
		vectors_ready = 1'b1;

		repeat (RESET_CYCLES) @(posedge sys_clk);
		@(negedge sys_clk);
		reset = 1'b0;
		@(negedge sys_clk);

		foreach (vec_op[i]) begin
			run_bus_cycle(vec_op[i], vec_addr[i], vec_wdata[i], vec_cart[i], vec_vdp[i],
				vec_joy_a[i], vec_joy_b[i], vec_expect[i], vec_name[i]);
		end

		// write one mirror and read back through another
		for (int p = 0; p < N_PAIRS; p++) begin
			rng_state = next_random(rng_state);
			wa = {2'b11, rng_state[13:0]};
			wd = rng_state[23:16];
			run_bus_cycle("MW", wa, wd, 8'h00, 8'h00, 8'hff, 8'hff, 8'h00,
				$sformatf("random_write_%0d", p));
			rng_state = next_random(rng_state);
			ra = {2'b11, rng_state[13:11], wa[10:0]};
			run_bus_cycle("MR", ra, 8'h00, 8'h00, 8'h00, 8'hff, 8'hff, ram_model[ra[10:0]],
				$sformatf("random_read_%0d", p));
		end

		$display("Checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: tests/sg1000_bus_tests.txt
# op addr wdata cart_data vdp_data joy_a joy_b expected_rdata name (hex, one bus cycle per line)
# op is MW/MR memory write/read or IW/IR i/o write/read; expected is only used by reads
MW C123 5A 00 00 FF FF 00 wram_write_c123
MR C123 00 00 00 FF FF 5A wram_read_c123
MR D123 00 00 00 FF FF 5A wram_mirror_d123
MR F123 00 00 00 FF FF 5A wram_mirror_f123
MW C7FF A5 00 00 FF FF 00 wram_write_c7ff
MR FFFF 00 00 00 FF FF A5 wram_mirror_ffff
MW E000 3C 00 00 FF FF 00 wram_write_e000
MR C000 00 00 00 FF FF 3C wram_mirror_c000
MR 0000 00 11 00 FF FF 11 cart_read_0000
MR 8123 00 C4 00 FF FF C4 cart_read_8123
MR BFFF 00 7E 00 FF FF 7E cart_read_bfff
MR 4000 00 99 00 FF FF 99 cart_read_4000
IR 0080 00 00 42 FF FF 42 vdp_read_data
IR 0081 00 00 9F FF FF 9F vdp_read_ctrl
IW 0080 12 00 00 FF FF 00 vdp_write_data
IW 00BF 87 00 00 FF FF 00 vdp_write_ctrl
IR 00BE 00 00 E1 FF FF E1 vdp_read_be
IR 00C0 00 00 00 FE 7F FE joy_read_a_c0
IR 00C1 00 00 00 FE 7F 7F joy_read_b_c1
IR 00FE 00 00 00 BF DF BF joy_read_a_fe
IR 00FF 00 00 00 BF DF DF joy_read_b_ff
IR 12C0 00 00 00 5A A5 5A joy_read_high_addr
IR 0000 00 00 00 FF FF 00 open_bus_port_00
IR 003F 00 00 00 FF FF 00 open_bus_port_3f
IR 0040 00 00 00 FF FF 00 open_bus_psg_read
IW 007F 85 00 00 FF FF 00 psg_latch_tone0
IW 007F 3F 00 00 FF FF 00 psg_data_tone0
IW 0040 9A 00 00 FF FF 00 psg_latch_vol0
IW 0041 07 00 00 FF FF 00 psg_data_vol0
IW 007F C3 00 00 FF FF 00 psg_latch_tone2
IW 007F 12 00 00 FF FF 00 psg_data_tone2
IW 0050 E6 00 00 FF FF 00 psg_latch_noise
IW 0050 2C 00 00 FF FF 00 psg_data_noise
IW 007F A1 00 00 FF FF 00 psg_latch_tone1
IW 007F 8F 00 00 FF FF 00 psg_relatch_tone0
IW 007F 00 00 00 FF FF 00 psg_data_tone0_zero
IW 007F FF 00 00 FF FF 00 psg_latch_vol3
MR D123 00 00 00 FF FF 5A wram_after_io
